//--- design/dispatchPkg.sv
// ######################################
// Dispatch stage shared definitions
// Field widths and per-lane packet formats
// ######################################
package dispatchPkg;

  localparam int DispatchWidth = 4;  // Lanes per bundle
  localparam int Checkpoints   = 8;  // Branch checkpoints in flight

  localparam int PcBits      = 32;
  localparam int ArchRegBits = 5;
  localparam int PhysRegBits = 7;
  localparam int ImmBits     = 16;
  localparam int OpcodeBits  = 8;
  localparam int OccCntBits  = 8;

  typedef logic [PcBits-1:0]              pc_t;
  typedef logic [ArchRegBits-1:0]         archReg_t;
  typedef logic [PhysRegBits-1:0]         physReg_t;
  typedef logic [Checkpoints-1:0]         ckptMask_t;  // One bit per live checkpoint
  typedef logic [$clog2(Checkpoints)-1:0] ckptId_t;
  typedef logic [ImmBits-1:0]             imm_t;
  typedef logic [OpcodeBits-1:0]          opcode_t;
  typedef logic [OccCntBits-1:0]          occCnt_t;    // Capacities up to 255
  typedef logic [$clog2(DispatchWidth):0] ldstCnt_t;   // Holds 0 up to DispatchWidth

  // Instruction as it leaves rename
  typedef struct packed {
    archReg_t  logDest;
    logic      isStore;
    logic      isLoad;
    ckptMask_t branchMask;   // Unresolved branches this one depends on
    ckptId_t   ckptId;
    physReg_t  srcPhys1;
    physReg_t  srcPhys2;
    physReg_t  destPhys;
    physReg_t  oldDestPhys;  // Freed at retire
    logic      destValid;
    imm_t      imm;
    opcode_t   opcode;
    pc_t       pc;
  } renamedPkt_t;

  // Issue queue entry, mask already updated
  typedef struct packed {
    logic      isStore;
    logic      isLoad;
    ckptMask_t branchMask;
    ckptId_t   ckptId;
    physReg_t  srcPhys1;
    physReg_t  srcPhys2;
    physReg_t  destPhys;
    physReg_t  oldDestPhys;
    logic      destValid;
    imm_t      imm;
    opcode_t   opcode;
    pc_t       pc;
  } issueqPkt_t;

  // Active list entry for in-order retire
  typedef struct packed {
    logic     isLoad;
    logic     isStore;
    pc_t      pc;
    archReg_t logDest;
    physReg_t destPhys;
    physReg_t oldDestPhys;
    logic     destValid;
  } alPkt_t;

  typedef struct packed {
    ckptMask_t branchMask;
    logic      isStore;
    logic      isLoad;
  } lsqPkt_t;

  typedef renamedPkt_t [DispatchWidth-1:0] renamedBundle_t;
  typedef issueqPkt_t  [DispatchWidth-1:0] issueqBundle_t;
  typedef alPkt_t      [DispatchWidth-1:0] alBundle_t;
  typedef lsqPkt_t     [DispatchWidth-1:0] lsqBundle_t;
  typedef ckptMask_t   [DispatchWidth-1:0] maskBundle_t;

endpackage

//--- design/capacityCheck.sv
// ######################################
// Back-end capacity check
// Stalls dispatch when any back-end queue would overflow
// ######################################
`timescale 1ns/1ps

module capacityCheck #(
  parameter int IssueQSize     = 32,
  parameter int ActiveListSize = 64,
  parameter int LsqSize        = 16
) (
  input  dispatchPkg::renamedBundle_t bundle_i,
  input  dispatchPkg::occCnt_t        loadQueueCnt_i,
  input  dispatchPkg::occCnt_t        storeQueueCnt_i,
  input  dispatchPkg::occCnt_t        issueQueueCnt_i,
  input  dispatchPkg::occCnt_t        activeListCnt_i,
  output logic                        stall_o
);

  import dispatchPkg::*;

  ldstCnt_t loadCnt;
  ldstCnt_t storeCnt;
  logic     loadFull;
  logic     storeFull;
  logic     issueFull;
  logic     activeFull;

  // Loads and stores in the incoming bundle
  always_comb
  begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int lane = 0; lane < DispatchWidth; lane++)
    begin
      loadCnt  = loadCnt + ldstCnt_t'(bundle_i[lane].isLoad);
      storeCnt = storeCnt + ldstCnt_t'(bundle_i[lane].isStore);
    end
  end

  // Sums taken at int width so a count near 255 cannot wrap
  assign loadFull   = (int'(loadQueueCnt_i) + int'(loadCnt)) > LsqSize;
  assign storeFull  = (int'(storeQueueCnt_i) + int'(storeCnt)) > LsqSize;

  // Every lane takes an issue queue and active list slot
  assign issueFull  = (int'(issueQueueCnt_i) + DispatchWidth) > IssueQSize;
  assign activeFull = (int'(activeListCnt_i) + DispatchWidth) > ActiveListSize;

  assign stall_o = loadFull | storeFull | issueFull | activeFull;

endmodule

//--- design/packetBuilder.sv
// ######################################
// Dispatch packet builder
// Clears the verified branch bit and splits each lane
// ######################################
`timescale 1ns/1ps

module packetBuilder (
  input  dispatchPkg::renamedBundle_t bundle_i,
  input  logic                        ctrlVerified_i,
  input  dispatchPkg::ckptId_t        ctrlVerifiedId_i,
  output dispatchPkg::maskBundle_t    masks_o,
  output dispatchPkg::issueqBundle_t  issueq_o,
  output dispatchPkg::alBundle_t      al_o,
  output dispatchPkg::lsqBundle_t     lsq_o
);

  import dispatchPkg::*;

  // A branch resolved correctly, so no lane depends on its checkpoint any more.
  // The same masks go back to the rename pipe registers for a held bundle.
  always_comb
  begin
    for (int lane = 0; lane < DispatchWidth; lane++)
    begin
      masks_o[lane] = bundle_i[lane].branchMask;
      if (ctrlVerified_i)
      begin
        masks_o[lane][ctrlVerifiedId_i] = 1'b0;
      end
    end
  end

  // Issue queue packets carry everything except the logical destination
  always_comb
  begin
    for (int lane = 0; lane < DispatchWidth; lane++)
    begin
      issueq_o[lane].isStore     = bundle_i[lane].isStore;
      issueq_o[lane].isLoad      = bundle_i[lane].isLoad;
      issueq_o[lane].branchMask  = masks_o[lane];  // Updated mask
      issueq_o[lane].ckptId      = bundle_i[lane].ckptId;
      issueq_o[lane].srcPhys1    = bundle_i[lane].srcPhys1;
      issueq_o[lane].srcPhys2    = bundle_i[lane].srcPhys2;
      issueq_o[lane].destPhys    = bundle_i[lane].destPhys;
      issueq_o[lane].oldDestPhys = bundle_i[lane].oldDestPhys;
      issueq_o[lane].destValid   = bundle_i[lane].destValid;
      issueq_o[lane].imm         = bundle_i[lane].imm;
      issueq_o[lane].opcode      = bundle_i[lane].opcode;
      issueq_o[lane].pc          = bundle_i[lane].pc;
    end
  end

  // Active list keeps only what retire and recovery need
  always_comb
  begin
    for (int lane = 0; lane < DispatchWidth; lane++)
    begin
      al_o[lane].isLoad      = bundle_i[lane].isLoad;
      al_o[lane].isStore     = bundle_i[lane].isStore;
      al_o[lane].pc          = bundle_i[lane].pc;
      al_o[lane].logDest     = bundle_i[lane].logDest;
      al_o[lane].destPhys    = bundle_i[lane].destPhys;
      al_o[lane].oldDestPhys = bundle_i[lane].oldDestPhys;  // Returned to free list
      al_o[lane].destValid   = bundle_i[lane].destValid;
    end
  end

  // LSQ needs the mask for squash and the access kind
  always_comb
  begin
    for (int lane = 0; lane < DispatchWidth; lane++)
    begin
      lsq_o[lane].branchMask = masks_o[lane];
      lsq_o[lane].isStore    = bundle_i[lane].isStore;
      lsq_o[lane].isLoad     = bundle_i[lane].isLoad;
    end
  end

endmodule

//--- design/dispatchLatch.sv
// ######################################
// Dispatch output register
// Holds the back-end packets for one cycle with a valid
// ######################################
`timescale 1ns/1ps

module dispatchLatch (
  input  logic                       clk,
  input  logic                       rstN_i,
  input  logic                       load_i,    // Bundle accepted this cycle
  input  dispatchPkg::issueqBundle_t issueq_i,
  input  dispatchPkg::alBundle_t     al_i,
  input  dispatchPkg::lsqBundle_t    lsq_i,
  output dispatchPkg::issueqBundle_t issueq_o,
  output dispatchPkg::alBundle_t     al_o,
  output dispatchPkg::lsqBundle_t    lsq_o,
  output logic                       valid_o
);

  // Valid follows load by one cycle, so back-to-back loads give back-to-back valids
  always_ff @(posedge clk)
  begin
    if (!rstN_i)
    begin
      valid_o <= 1'b0;
    end
    else
    begin
      valid_o <= load_i;
    end
  end

  // Packets only move on an accepted bundle
  always_ff @(posedge clk)
  begin
    if (load_i)
    begin
      issueq_o <= issueq_i;
      al_o     <= al_i;
      lsq_o    <= lsq_i;
    end
  end

endmodule

//--- design/dispatchTop.sv
// ######################################
// Dispatch stage
// Capacity check, mask update and packet register
// ######################################
`timescale 1ns/1ps

module dispatchTop #(
  parameter int IssueQSize     = 32,
  parameter int ActiveListSize = 64,
  parameter int LsqSize        = 16
) (
  input  logic                        clk,
  input  logic                        rstN_i,
  input  logic                        renameReady_i,    // Rename holds a full bundle
  input  logic                        flagRecoverEX_i,  // Mispredict recovery under way
  input  logic                        ctrlVerified_i,
  input  dispatchPkg::ckptId_t        ctrlVerifiedId_i,
  input  dispatchPkg::renamedBundle_t renamedBundle_i,
  input  dispatchPkg::occCnt_t        loadQueueCnt_i,
  input  dispatchPkg::occCnt_t        storeQueueCnt_i,
  input  dispatchPkg::occCnt_t        issueQueueCnt_i,
  input  dispatchPkg::occCnt_t        activeListCnt_i,
  output dispatchPkg::issueqBundle_t  issueqBundle_o,
  output dispatchPkg::alBundle_t      alBundle_o,
  output dispatchPkg::lsqBundle_t     lsqBundle_o,
  output logic                        dispatchValid_o,
  output dispatchPkg::maskBundle_t    updatedMasks_o,
  output logic                        backEndReady_o,
  output logic                        stallFrontEnd_o
);

  import dispatchPkg::*;

  logic          stall;
  issueqBundle_t issueqNext;
  alBundle_t     alNext;
  lsqBundle_t    lsqNext;

  capacityCheck #(
    .IssueQSize     (IssueQSize),
    .ActiveListSize (ActiveListSize),
    .LsqSize        (LsqSize)
  ) capCheck0 (
    .bundle_i        (renamedBundle_i),
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .stall_o         (stall)
  );

  packetBuilder pktBuild0 (
    .bundle_i         (renamedBundle_i),
    .ctrlVerified_i   (ctrlVerified_i),
    .ctrlVerifiedId_i (ctrlVerifiedId_i),
    .masks_o          (updatedMasks_o),
    .issueq_o         (issueqNext),
    .al_o             (alNext),
    .lsq_o            (lsqNext)
  );

  // Recovery blocks dispatch but is not a capacity stall
  assign backEndReady_o  = ~stall & renameReady_i & ~flagRecoverEX_i;
  assign stallFrontEnd_o = stall;

  dispatchLatch dispLatch0 (
    .clk      (clk),
    .rstN_i   (rstN_i),
    .load_i   (backEndReady_o),
    .issueq_i (issueqNext),
    .al_i     (alNext),
    .lsq_i    (lsqNext),
    .issueq_o (issueqBundle_o),
    .al_o     (alBundle_o),
    .lsq_o    (lsqBundle_o),
    .valid_o  (dispatchValid_o)
  );

endmodule

//--- tb/dispatchModel.svh
// ########################################
// Dispatch stage reference model
// Expected stall, masks and back-end packets
// ########################################
`ifndef DISPATCH_MODEL_SVH
`define DISPATCH_MODEL_SVH

// Loads (stores = 0) or stores (stores = 1) in one bundle
function automatic int countAccesses(input dispatchPkg::renamedBundle_t b, input logic stores);
  int n;
  n = 0;
  for (int lane = 0; lane < dispatchPkg::DispatchWidth; lane++)
  begin
    n += stores ? int'(b[lane].isStore) : int'(b[lane].isLoad);
  end
  return n;
endfunction

// Stall when any back-end structure would take more entries than it holds
function automatic logic expectStall(
  input dispatchPkg::renamedBundle_t b,
  input dispatchPkg::occCnt_t        ldCnt,
  input dispatchPkg::occCnt_t        stCnt,
  input dispatchPkg::occCnt_t        iqCnt,
  input dispatchPkg::occCnt_t        alCnt,
  input int                          iqSize,
  input int                          alSize,
  input int                          lsqSize
);
  int width;
  width = dispatchPkg::DispatchWidth;  // Every lane needs an IQ and AL entry
  return (int'(ldCnt) + countAccesses(b, 1'b0) > lsqSize)
      || (int'(stCnt) + countAccesses(b, 1'b1) > lsqSize)
      || (int'(iqCnt) + width > iqSize)
      || (int'(alCnt) + width > alSize);
endfunction

function automatic logic expectReady(input logic stall, input logic ready, input logic recover);
  return !stall && ready && !recover;
endfunction

function automatic dispatchPkg::maskBundle_t expectMasks(
  input dispatchPkg::renamedBundle_t b,
  input logic                        verified,
  input dispatchPkg::ckptId_t        id
);
  dispatchPkg::maskBundle_t  m;
  dispatchPkg::ckptMask_t    clearBit;
  clearBit = verified ? (dispatchPkg::ckptMask_t'(1) << id) : '0;
  for (int lane = 0; lane < dispatchPkg::DispatchWidth; lane++)
  begin
    m[lane] = b[lane].branchMask & ~clearBit;
  end
  return m;
endfunction

function automatic dispatchPkg::issueqBundle_t expectIssueq(
  input dispatchPkg::renamedBundle_t b,
  input dispatchPkg::maskBundle_t    m
);
  dispatchPkg::issueqBundle_t q;
  for (int lane = 0; lane < dispatchPkg::DispatchWidth; lane++)
  begin
    q[lane] = '{isStore: b[lane].isStore, isLoad: b[lane].isLoad, branchMask: m[lane],
                ckptId: b[lane].ckptId, srcPhys1: b[lane].srcPhys1,
                srcPhys2: b[lane].srcPhys2, destPhys: b[lane].destPhys,
                oldDestPhys: b[lane].oldDestPhys, destValid: b[lane].destValid,
                imm: b[lane].imm, opcode: b[lane].opcode, pc: b[lane].pc};
  end
  return q;
endfunction

function automatic dispatchPkg::alBundle_t expectAl(input dispatchPkg::renamedBundle_t b);
  dispatchPkg::alBundle_t a;
  for (int lane = 0; lane < dispatchPkg::DispatchWidth; lane++)
  begin
    a[lane] = '{isLoad: b[lane].isLoad, isStore: b[lane].isStore, pc: b[lane].pc,
                logDest: b[lane].logDest, destPhys: b[lane].destPhys,
                oldDestPhys: b[lane].oldDestPhys, destValid: b[lane].destValid};
  end
  return a;
endfunction

function automatic dispatchPkg::lsqBundle_t expectLsq(
  input dispatchPkg::renamedBundle_t b,
  input dispatchPkg::maskBundle_t    m
);
  dispatchPkg::lsqBundle_t l;
  for (int lane = 0; lane < dispatchPkg::DispatchWidth; lane++)
  begin
    l[lane] = '{branchMask: m[lane], isStore: b[lane].isStore, isLoad: b[lane].isLoad};
  end
  return l;
endfunction

`endif

//--- tb/dispatchTb.sv
// ########################################
// Dispatch stage testbench
// Random bundles checked against a reference model
// ########################################
`timescale 1ns/1ps

module dispatchTb;

  import dispatchPkg::*;

  localparam int IssueQSize     = 32;
  localparam int ActiveListSize = 64;
  localparam int LsqSize        = 16;

  localparam int NumRandom     = 20;
  localparam int NumMask       = 16;
  localparam int NumCapRounds  = 3;  // Eight cycles each
  localparam int NumRecover    = 4;
  localparam int NumBackToBack = 8;
  localparam int TestCycles    = 2 + 3 + NumRandom + NumMask + 8 * NumCapRounds
                                 + NumRecover + 2 + NumBackToBack + 2;
  localparam int TimeoutCycles = 2 * TestCycles + 20;

  `include "dispatchModel.svh"

  logic           clk = 1'b0;
  logic           rstN;
  logic           renameReady;
  logic           flagRecoverEX;
  logic           ctrlVerified;
  ckptId_t        ctrlVerifiedId;
  renamedBundle_t renamedBundle;
  occCnt_t        loadQueueCnt;
  occCnt_t        storeQueueCnt;
  occCnt_t        issueQueueCnt;
  occCnt_t        activeListCnt;
  issueqBundle_t  issueqBundle;
  alBundle_t      alBundle;
  lsqBundle_t     lsqBundle;
  logic           dispatchValid;
  maskBundle_t    updatedMasks;
  logic           backEndReady;
  logic           stallFrontEnd;

  int             seed;
  int             cycleCnt = 0;
  int             checkCount = 0;
  string          testName;
  string          checkName;

  // Expected values taken at the rising edge
  logic           stallExp;
  logic           readyExp;
  logic           validExp;
  maskBundle_t    masksExp;
  issueqBundle_t  issueqExp;
  alBundle_t      alExp;
  lsqBundle_t     lsqExp;

  dispatchTop #(
    .IssueQSize     (IssueQSize),
    .ActiveListSize (ActiveListSize),
    .LsqSize        (LsqSize)
  ) dut0 (
    .clk              (clk),
    .rstN_i           (rstN),
    .renameReady_i    (renameReady),
    .flagRecoverEX_i  (flagRecoverEX),
    .ctrlVerified_i   (ctrlVerified),
    .ctrlVerifiedId_i (ctrlVerifiedId),
    .renamedBundle_i  (renamedBundle),
    .loadQueueCnt_i   (loadQueueCnt),
    .storeQueueCnt_i  (storeQueueCnt),
    .issueQueueCnt_i  (issueQueueCnt),
    .activeListCnt_i  (activeListCnt),
    .issueqBundle_o   (issueqBundle),
    .alBundle_o       (alBundle),
    .lsqBundle_o      (lsqBundle),
    .dispatchValid_o  (dispatchValid),
    .updatedMasks_o   (updatedMasks),
    .backEndReady_o   (backEndReady),
    .stallFrontEnd_o  (stallFrontEnd)
  );

  always #5 clk = ~clk;

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "run stopped");
  endtask

  task automatic checkBit(input string name, input logic expVal, input logic actVal);
    checkCount++;
    if (actVal !== expVal)
    begin
      abortRun($sformatf("error: %s expected %b actual %b", name, expVal, actVal));
    end
  endtask

  task automatic checkMasks(input string name, input maskBundle_t expVal,
                            input maskBundle_t actVal);
    checkCount++;
    if (actVal !== expVal)
    begin
      abortRun($sformatf("error: %s expected %h actual %h", name, expVal, actVal));
    end
  endtask

  task automatic checkIssueq(input string name, input issueqBundle_t expVal,
                             input issueqBundle_t actVal);
    checkCount++;
    if (actVal !== expVal)
    begin
      abortRun($sformatf("error: %s expected %h actual %h", name, expVal, actVal));
    end
  endtask

  task automatic checkAl(input string name, input alBundle_t expVal, input alBundle_t actVal);
    checkCount++;
    if (actVal !== expVal)
    begin
      abortRun($sformatf("error: %s expected %h actual %h", name, expVal, actVal));
    end
  endtask

  task automatic checkLsq(input string name, input lsqBundle_t expVal, input lsqBundle_t actVal);
    checkCount++;
    if (actVal !== expVal)
    begin
      abortRun($sformatf("error: %s expected %h actual %h", name, expVal, actVal));
    end
  endtask

  task automatic randomBundle(output renamedBundle_t b);
    logic [127:0] raw;
    for (int lane = 0; lane < DispatchWidth; lane++)
    begin
      raw     = {$random(seed), $random(seed), $random(seed), $random(seed)};
      b[lane] = raw[$bits(renamedPkt_t)-1:0];
      if (b[lane].isLoad)
      begin
        b[lane].isStore = 1'b0;  // One memory access per instruction
      end
    end
  endtask

  task automatic setCounts(input int ld, input int st, input int iq, input int al);
    loadQueueCnt  = occCnt_t'(ld);
    storeQueueCnt = occCnt_t'(st);
    issueQueueCnt = occCnt_t'(iq);
    activeListCnt = occCnt_t'(al);
  endtask

  // Inputs settle at the falling edge, so combinational outputs are read at the
  // rising edge and the registered packets at the falling edge after it
  always
  begin
    @(posedge clk);
    checkName = testName;
    stallExp  = expectStall(renamedBundle, loadQueueCnt, storeQueueCnt, issueQueueCnt,
                            activeListCnt, IssueQSize, ActiveListSize, LsqSize);
    readyExp  = expectReady(stallExp, renameReady, flagRecoverEX);
    masksExp  = expectMasks(renamedBundle, ctrlVerified, ctrlVerifiedId);
    checkBit({checkName, " stallFrontEnd"}, stallExp, stallFrontEnd);
    checkBit({checkName, " backEndReady"}, readyExp, backEndReady);
    checkMasks({checkName, " updatedMasks"}, masksExp, updatedMasks);
    validExp  = rstN & readyExp;
    issueqExp = expectIssueq(renamedBundle, masksExp);
    alExp     = expectAl(renamedBundle);
    lsqExp    = expectLsq(renamedBundle, masksExp);
    @(negedge clk);
    checkBit({checkName, " dispatchValid"}, validExp, dispatchValid);
    if (validExp)
    begin
      checkIssueq({checkName, " issueqBundle"}, issueqExp, issueqBundle);
      checkAl({checkName, " alBundle"}, alExp, alBundle);
      checkLsq({checkName, " lsqBundle"}, lsqExp, lsqBundle);
    end
  end

  always @(posedge clk)
  begin
    cycleCnt = cycleCnt + 1;
    if (cycleCnt >= TimeoutCycles)
    begin
      abortRun("Timeout: the tests did not finish within the cycle limit");
    end
  end

  initial
  begin
    int nLoads;
    int nStores;
    seed           = 32'h74b9;
    testName       = "reset";
    rstN           = 1'b0;
    renameReady    = 1'b0;
    flagRecoverEX  = 1'b0;
    ctrlVerified   = 1'b0;
    ctrlVerifiedId = '0;
    renamedBundle  = '0;
    setCounts(0, 0, 0, 0);
    repeat (2) @(negedge clk);
    rstN = 1'b1;
    repeat (3) @(negedge clk);  // Rename not ready yet

    testName    = "packet";
    renameReady = 1'b1;
    repeat (NumRandom)
    begin
      randomBundle(renamedBundle);
      @(negedge clk);
    end

    testName     = "maskUpdate";
    ctrlVerified = 1'b1;
    repeat (NumMask)
    begin
      randomBundle(renamedBundle);
      ctrlVerifiedId = ckptId_t'($random(seed));
      renamedBundle[0].branchMask[ctrlVerifiedId] = 1'b1;  // Bit to clear is set
      @(negedge clk);
    end
    ctrlVerified = 1'b0;

    // Each occupancy at its limit, then one over
    testName = "capacity";
    repeat (NumCapRounds)
    begin
      randomBundle(renamedBundle);
      nLoads  = countAccesses(renamedBundle, 1'b0);
      nStores = countAccesses(renamedBundle, 1'b1);
      for (int kind = 0; kind < 4; kind++)
      begin
        for (int over = 0; over < 2; over++)
        begin
          case (kind)
            0:       setCounts(LsqSize - nLoads + over, 0, 0, 0);
            1:       setCounts(0, LsqSize - nStores + over, 0, 0);
            2:       setCounts(0, 0, IssueQSize - DispatchWidth + over, 0);
            default: setCounts(0, 0, 0, ActiveListSize - DispatchWidth + over);
          endcase
          @(negedge clk);
        end
      end
    end
    setCounts(0, 0, 0, 0);

    testName      = "recovery";
    flagRecoverEX = 1'b1;
    repeat (NumRecover)
    begin
      randomBundle(renamedBundle);
      @(negedge clk);
    end
    setCounts(0, 0, IssueQSize, 0);  // Recovery on top of a full issue queue
    repeat (2) @(negedge clk);
    setCounts(0, 0, 0, 0);
    flagRecoverEX = 1'b0;

    testName = "backToBack";
    repeat (NumBackToBack)
    begin
      randomBundle(renamedBundle);
      ctrlVerified   = 1'($random(seed));
      ctrlVerifiedId = ckptId_t'($random(seed));
      @(negedge clk);
    end

    testName     = "drain";
    renameReady  = 1'b0;
    ctrlVerified = 1'b0;
    repeat (2) @(negedge clk);
    #1;  // Let the last falling-edge check complete

    if (checkCount > 0)
    begin
      $display("Testbench passed");
      $finish;
    end
    else
    begin
      abortRun("No checks were performed");
    end
  end

endmodule

//--- dispatch.f
+incdir+tb
design/dispatchPkg.sv
design/capacityCheck.sv
design/packetBuilder.sv
design/dispatchLatch.sv
design/dispatchTop.sv
tb/dispatchTb.sv

//--- Makefile
# Verilator build and run of the dispatch stage testbench

TOP       ?= dispatchTb
FILELIST  ?= dispatch.f
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir
PASS_TEXT ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -j 0 --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
